//--- compile.f
source/conv_pkg.sv
source/fixed_point_multiplier.sv
source/operand_join.sv
source/convolution_block.sv
source/convolution_unit.sv
tb/convolution_unit_properties.sv
tb/tb_convolution_unit.sv

//--- Bender.yml
package:
  name: convolution_unit

sources:
  # rtl in compile order, package first
  - source/conv_pkg.sv
  - source/fixed_point_multiplier.sv
  - source/operand_join.sv
  - source/convolution_block.sv
  - source/convolution_unit.sv

  # testbench and bound checks
  - target: test
    files:
      - tb/convolution_unit_properties.sv
      - tb/tb_convolution_unit.sv

//--- tb/tb_convolution_unit.sv
// ==============================
// convolution unit testbench
// directed, random, stall and latency jobs
// ==============================
`default_nettype none

module tb_convolution_unit
  import conv_pkg::*;
();

  localparam int BIT_WIDTH       = DEFAULT_BIT_WIDTH;
  localparam int ARRAY_LENGTH    = DEFAULT_ARRAY_LENGTH;
  localparam int FRAC_BITS       = DEFAULT_FRAC_BITS;
  localparam int FLAT_W          = BIT_WIDTH * ARRAY_LENGTH;
  localparam int HALF_PERIOD     = 20;
  localparam int DRIVE_DELAY     = 2;
  localparam int RESET_CYCLES    = 4;
  localparam int RANDOM_JOBS     = 40;
  localparam int TOTAL_JOBS      = RANDOM_JOBS + 3;
  localparam int MAX_STALL       = 8;
  localparam int MAX_GAP         = 4;
  localparam int WATCHDOG_CYCLES =
    4 * (RESET_CYCLES + TOTAL_JOBS * (BIT_WIDTH + 2 + MAX_STALL + MAX_GAP));

  logic                 clk;
  logic                 rst_n;
  logic                 input_val;
  logic                 input_rdy;
  logic [BIT_WIDTH-1:0] input_msg [ARRAY_LENGTH-1:0];
  logic                 filter_val;
  logic                 filter_rdy;
  logic [BIT_WIDTH-1:0] filter_msg [ARRAY_LENGTH-1:0];
  logic                 output_val;
  logic                 output_rdy;
  logic [BIT_WIDTH-1:0] output_msg [ARRAY_LENGTH-1:0];

  // scoreboard and bookkeeping
  logic [FLAT_W-1:0]    exp_q [$];
  logic [FLAT_W-1:0]    popped;
  logic [FLAT_W-1:0]    in_f;
  logic [FLAT_W-1:0]    flt_f;
  logic [BIT_WIDTH-1:0] held_msg [ARRAY_LENGTH-1:0];
  logic [31:0]          lfsr_state = 32'hbd19_281f;
  logic                 hold_pending;
  logic                 stall_enable;
  logic                 next_rdy;
  int                   stall_left;
  int                   mismatch_count;
  int                   other_count;
  int                   jobs_sent;
  int                   jobs_checked;
  int                   held_cycles;
  int                   order;
  int                   gap;

  convolution_unit u_convolution_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .input_val  (input_val),
    .input_rdy  (input_rdy),
    .input_msg  (input_msg),
    .filter_val (filter_val),
    .filter_rdy (filter_rdy),
    .filter_msg (filter_msg),
    .output_val (output_val),
    .output_rdy (output_rdy),
    .output_msg (output_msg)
  );

  always #HALF_PERIOD clk = ~clk;

  // ==============================
  // random source and reference
  // ==============================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // magnitude product, sign applied, arithmetic shift, low word kept
  function automatic logic [BIT_WIDTH-1:0] ref_product(input logic [BIT_WIDTH-1:0] a,
                                                       input logic [BIT_WIDTH-1:0] b);
    longint sa;
    longint sb;
    longint p;
    sa = $signed(a);
    sb = $signed(b);
    p  = (sa < 0 ? -sa : sa) * (sb < 0 ? -sb : sb);
    if ((sa < 0) != (sb < 0)) p = -p;
    p = p >>> FRAC_BITS;
    return p[BIT_WIDTH-1:0];
  endfunction

  // lane i pairs input[i] with the mirrored filter element
  function automatic logic [FLAT_W-1:0] ref_conv(input logic [FLAT_W-1:0] a_f,
                                                 input logic [FLAT_W-1:0] b_f);
    logic [FLAT_W-1:0] r;
    r = '0;
    for (int i = 0; i < ARRAY_LENGTH; i++) begin
      r[i*BIT_WIDTH +: BIT_WIDTH] = ref_product(a_f[i*BIT_WIDTH +: BIT_WIDTH],
                                                b_f[(ARRAY_LENGTH-1-i)*BIT_WIDTH +: BIT_WIDTH]);
    end
    return r;
  endfunction

  // ==============================
  // checks
  // ==============================
  task automatic check_word(input string name, input logic [BIT_WIDTH-1:0] got,
                            input logic [BIT_WIDTH-1:0] expected);
    if (got !== expected) begin
      $display("Mismatch %s: got %h, expected %h", name, got, expected);
      mismatch_count++;
    end
  endtask

  task automatic check_state_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("Mismatch %s: got %h, expected %h", name, got, expected);
      mismatch_count++;
    end
  endtask

  task automatic check_reset_state();
    check_state_flag("input_rdy", input_rdy, 1'b1);
    check_state_flag("filter_rdy", filter_rdy, 1'b1);
    check_state_flag("output_val", output_val, 1'b0);
  endtask

  // ==============================
  // stimulus
  // ==============================
  // order 0 leads with the filter, 1 with the input, 2 sends both at once
  task automatic send_job(input logic [FLAT_W-1:0] a_f, input logic [FLAT_W-1:0] b_f,
                          input int lead, input int wait_cycles);
    logic in_done;
    logic flt_done;
    logic in_x;
    logic flt_x;
    in_done  = 1'b0;
    flt_done = 1'b0;
    for (int i = 0; i < ARRAY_LENGTH; i++) begin
      input_msg[i]  = a_f[i*BIT_WIDTH +: BIT_WIDTH];
      filter_msg[i] = b_f[i*BIT_WIDTH +: BIT_WIDTH];
    end
    input_val  = (lead != 0);
    filter_val = (lead != 1);
    while (!(in_done && flt_done)) begin
      // rdy never depends on val, so the negedge view decides the edge
      @(negedge clk);
      in_x  = input_val && input_rdy;
      flt_x = filter_val && filter_rdy;
      @(posedge clk);
      #DRIVE_DELAY;
      if (in_x) begin
        in_done   = 1'b1;
        input_val = 1'b0;
      end
      if (flt_x) begin
        flt_done   = 1'b1;
        filter_val = 1'b0;
      end
      // second operand after a short gap
      if ((in_done && !flt_done && !filter_val) || (flt_done && !in_done && !input_val)) begin
        repeat (wait_cycles) begin
          @(posedge clk);
          #DRIVE_DELAY;
        end
        input_val  = !in_done;
        filter_val = !flt_done;
      end
    end
    exp_q.push_back(ref_conv(a_f, b_f));
    jobs_sent++;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // output_val must rise exactly BIT_WIDTH+2 edges after the operand edge
  task automatic run_latency_job(input logic [FLAT_W-1:0] a_f, input logic [FLAT_W-1:0] b_f);
    send_job(a_f, b_f, 2, 0);
    for (int n = 0; n <= BIT_WIDTH + 2; n++) begin
      @(negedge clk);
      check_state_flag("output_val", output_val, n == BIT_WIDTH + 2);
    end
  endtask

  // random output stalls, decided at negedge and applied after the edge
  always begin
    @(negedge clk);
    if (stall_left > 0) begin
      stall_left--;
      next_rdy = 1'b0;
    end else if (stall_enable && rand_bits(2) == 0) begin
      stall_left = rand_bits(3);
      next_rdy   = 1'b0;
    end else begin
      next_rdy = 1'b1;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    output_rdy = next_rdy;
  end

  // ==============================
  // compare process
  // ==============================
  always @(negedge clk) begin
    if (rst_n) begin
      if (hold_pending) begin
        check_state_flag("output_val", output_val, 1'b1);
        for (int i = 0; i < ARRAY_LENGTH; i++)
          check_word($sformatf("output_msg[%0d]", i), output_msg[i], held_msg[i]);
      end
      // joiner full while the block waits on a stall
      if (output_val && !output_rdy && !input_rdy && !filter_rdy) held_cycles++;
      if (output_val && output_rdy) begin
        if (exp_q.size() == 0) begin
          $display("unexpected output array with no job outstanding");
          other_count++;
        end else begin
          popped = exp_q.pop_front();
          for (int i = 0; i < ARRAY_LENGTH; i++)
            check_word($sformatf("output_msg[%0d]", i), output_msg[i],
                       popped[i*BIT_WIDTH +: BIT_WIDTH]);
          jobs_checked++;
        end
      end
      hold_pending = output_val && !output_rdy;
      held_msg     = output_msg;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, %0d jobs outstanding",
             WATCHDOG_CYCLES, exp_q.size());
    $display("SOME TESTS FAILED");
    $finish;
  end

  // ==============================
  // main sequence
  // ==============================
  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    input_val      = 1'b0;
    filter_val     = 1'b0;
    output_rdy     = 1'b1;
    stall_enable   = 1'b0;
    stall_left     = 0;
    hold_pending   = 1'b0;
    mismatch_count = 0;
    other_count    = 0;
    jobs_sent      = 0;
    jobs_checked   = 0;
    held_cycles    = 0;
    for (int i = 0; i < ARRAY_LENGTH; i++) begin
      input_msg[i]  = '0;
      filter_msg[i] = '0;
    end
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_reset_state();
    end
    @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    @(posedge clk);
    #DRIVE_DELAY;
    // zero, +-1.0, neg times neg, most negative word
    send_job({16'h8000, 16'h0000, 16'hff00, 16'h0100},
             {16'h0180, 16'h0100, 16'hfe80, 16'h0100}, 2, 0);
    send_job({16'h8000, 16'h7fff, 16'h0001, 16'hff00},
             {16'h8000, 16'hff00, 16'hffff, 16'h0100}, 0, 1);
    wait_drained();
    // random arrays under output stalls
    stall_enable = 1'b1;
    for (int j = 0; j < RANDOM_JOBS; j++) begin
      for (int i = 0; i < ARRAY_LENGTH; i++) begin
        in_f[i*BIT_WIDTH +: BIT_WIDTH]  = BIT_WIDTH'(rand_bits(BIT_WIDTH));
        flt_f[i*BIT_WIDTH +: BIT_WIDTH] = BIT_WIDTH'(rand_bits(BIT_WIDTH));
      end
      order = rand_bits(2) % 3;
      gap   = rand_bits(2);
      send_job(in_f, flt_f, order, gap);
    end
    wait_drained();
    stall_enable = 1'b0;
    run_latency_job({16'h0200, 16'hfc00, 16'h0080, 16'h1234},
                    {16'h0300, 16'h0040, 16'hff80, 16'h8001});
    wait_drained();
    // nothing repeated once every job is out
    repeat (BIT_WIDTH + 2) begin
      @(negedge clk);
      check_state_flag("output_val", output_val, 1'b0);
    end
    if (held_cycles == 0) begin
      $display("no operand pair was held in the joiner during an output stall");
      other_count++;
    end
    $display("summary: %0d mismatches, %0d other errors, %0d of %0d jobs checked",
             mismatch_count, other_count, jobs_checked, jobs_sent);
    if (mismatch_count + other_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/convolution_unit_properties.sv
// ==============================
// convolution unit stream checks
// bound into the top level
// ==============================
`default_nettype none

module convolution_unit_properties
  import conv_pkg::*;
#(
  parameter int BIT_WIDTH    = DEFAULT_BIT_WIDTH,
  parameter int ARRAY_LENGTH = DEFAULT_ARRAY_LENGTH
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 input_val,
  input logic                 input_rdy,
  input logic [BIT_WIDTH-1:0] input_msg [ARRAY_LENGTH-1:0],
  input logic                 filter_val,
  input logic                 filter_rdy,
  input logic [BIT_WIDTH-1:0] filter_msg [ARRAY_LENGTH-1:0],
  input logic                 output_val,
  input logic                 output_rdy,
  input logic [BIT_WIDTH-1:0] output_msg [ARRAY_LENGTH-1:0]
);

  // result valid held under back-pressure
  a_output_val_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (output_val && !output_rdy) |=> output_val)
    else $error("output_val dropped before its transfer");

  // payloads stable until taken, on all three streams
  for (genvar i = 0; i < ARRAY_LENGTH; i++) begin : g_hold
    a_output_msg_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (output_val && !output_rdy) |=> $stable(output_msg[i]))
      else $error("output_msg changed while stalled");
    a_input_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (input_val && !input_rdy) |=> (input_val && $stable(input_msg[i])))
      else $error("input stream released before its transfer");
    a_filter_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (filter_val && !filter_rdy) |=> (filter_val && $stable(filter_msg[i])))
      else $error("filter stream released before its transfer");
  end

  // reset values
  a_reset_values: assert property (@(posedge clk)
    !rst_n |-> (input_rdy && filter_rdy && !output_val))
    else $error("stream controls away from reset values in reset");

endmodule

bind convolution_unit convolution_unit_properties #(
  .BIT_WIDTH    (BIT_WIDTH),
  .ARRAY_LENGTH (ARRAY_LENGTH)
) u_properties (.*);

`default_nettype wire

//--- source/convolution_unit.sv
// ==============================
// convolution unit top level
// operand joiner feeding the convolution block
// ==============================
`default_nettype none

module convolution_unit
  import conv_pkg::*;
#(
  parameter int BIT_WIDTH    = DEFAULT_BIT_WIDTH,
  parameter int ARRAY_LENGTH = DEFAULT_ARRAY_LENGTH,
  parameter int FRAC_BITS    = DEFAULT_FRAC_BITS
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // input array
  input  logic                 input_val,
  output logic                 input_rdy,
  input  logic [BIT_WIDTH-1:0] input_msg [ARRAY_LENGTH-1:0],

  // filter array
  input  logic                 filter_val,
  output logic                 filter_rdy,
  input  logic [BIT_WIDTH-1:0] filter_msg [ARRAY_LENGTH-1:0],

  // output array
  output logic                 output_val,
  input  logic                 output_rdy,
  output logic [BIT_WIDTH-1:0] output_msg [ARRAY_LENGTH-1:0]
);

  // joiner to block
  logic                 pair_val;
  logic                 pair_rdy;
  logic [BIT_WIDTH-1:0] pair_input [ARRAY_LENGTH-1:0];
  logic [BIT_WIDTH-1:0] pair_filter [ARRAY_LENGTH-1:0];

  // decouples the two operand streams
  operand_join #(
    .BIT_WIDTH    (BIT_WIDTH),
    .ARRAY_LENGTH (ARRAY_LENGTH)
  ) u_join (
    .clk         (clk),
    .rst_n       (rst_n),
    .input_val   (input_val),
    .input_rdy   (input_rdy),
    .input_msg   (input_msg),
    .filter_val  (filter_val),
    .filter_rdy  (filter_rdy),
    .filter_msg  (filter_msg),
    .pair_val    (pair_val),
    .pair_rdy    (pair_rdy),
    .pair_input  (pair_input),
    .pair_filter (pair_filter)
  );

  // one pair computing here while the next waits in the joiner
  convolution_block #(
    .BIT_WIDTH    (BIT_WIDTH),
    .ARRAY_LENGTH (ARRAY_LENGTH),
    .FRAC_BITS    (FRAC_BITS)
  ) u_block (
    .clk         (clk),
    .rst_n       (rst_n),
    .pair_val    (pair_val),
    .pair_rdy    (pair_rdy),
    .pair_input  (pair_input),
    .pair_filter (pair_filter),
    .output_val  (output_val),
    .output_rdy  (output_rdy),
    .output_msg  (output_msg)
  );

endmodule

`default_nettype wire

//--- source/convolution_block.sv
// ==============================
// convolution block
// reversed elementwise products, one multiplier per lane
// ==============================
`default_nettype none

module convolution_block
  import conv_pkg::*;
#(
  parameter int BIT_WIDTH    = DEFAULT_BIT_WIDTH,
  parameter int ARRAY_LENGTH = DEFAULT_ARRAY_LENGTH,
  parameter int FRAC_BITS    = DEFAULT_FRAC_BITS
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // joined operand pair
  input  logic                 pair_val,
  output logic                 pair_rdy,
  input  logic [BIT_WIDTH-1:0] pair_input [ARRAY_LENGTH-1:0],
  input  logic [BIT_WIDTH-1:0] pair_filter [ARRAY_LENGTH-1:0],

  // result array
  output logic                 output_val,
  input  logic                 output_rdy,
  output logic [BIT_WIDTH-1:0] output_msg [ARRAY_LENGTH-1:0]
);

  conv_state_e state, state_next;

  logic                    fire;
  logic                    all_done;
  logic                    capture;
  logic                    mult_send_rdy;
  logic [ARRAY_LENGTH-1:0] send_val_bus;
  logic [BIT_WIDTH-1:0]    lane_prod [ARRAY_LENGTH-1:0];

  // ==============================
  // handshakes
  // ==============================

  // accept a pair only while idle
  assign pair_rdy   = (state == CONV_IDLE);
  assign fire       = pair_val && pair_rdy;
  assign output_val = (state == CONV_DONE);

  // lanes start together with equal latency, so they also finish together
  assign all_done = &send_val_bus;
  assign capture  = (state == CONV_CALC) && all_done;

  // results taken only while calculating, state based
  assign mult_send_rdy = (state == CONV_CALC);

  // ==============================
  // control fsm
  // ==============================
  always_comb begin
    state_next = state;
    case (state)
      CONV_IDLE: if (fire) state_next = CONV_CALC;
      CONV_CALC: if (all_done) state_next = CONV_DONE;
      CONV_DONE: if (output_rdy) state_next = CONV_IDLE;
      default:   state_next = CONV_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= CONV_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // result register, held through back-pressure
  always_ff @(posedge clk) begin
    if (capture) output_msg <= lane_prod;
  end

  // ==============================
  // multiplier lanes
  // ==============================
  // output[i] = input[i] * filter[n-1-i]
  // recv_rdy left open, every lane is idle whenever the fsm is idle
  for (genvar i = 0; i < ARRAY_LENGTH; i++) begin : g_lane
    fixed_point_multiplier #(
      .BIT_WIDTH (BIT_WIDTH),
      .FRAC_BITS (FRAC_BITS)
    ) u_mult (
      .clk      (clk),
      .rst_n    (rst_n),
      .recv_val (fire),
      .recv_rdy (),
      .a        (pair_input[i]),
      .b        (pair_filter[ARRAY_LENGTH-1-i]),
      .send_val (send_val_bus[i]),
      .send_rdy (mult_send_rdy),
      .c        (lane_prod[i])
    );
  end

endmodule

`default_nettype wire

//--- source/operand_join.sv
// ==============================
// operand joiner
// one-entry buffer per stream, joined pair out
// ==============================
`default_nettype none

module operand_join
  import conv_pkg::*;
#(
  parameter int BIT_WIDTH    = DEFAULT_BIT_WIDTH,
  parameter int ARRAY_LENGTH = DEFAULT_ARRAY_LENGTH
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // input array stream
  input  logic                 input_val,
  output logic                 input_rdy,
  input  logic [BIT_WIDTH-1:0] input_msg [ARRAY_LENGTH-1:0],

  // filter array stream
  input  logic                 filter_val,
  output logic                 filter_rdy,
  input  logic [BIT_WIDTH-1:0] filter_msg [ARRAY_LENGTH-1:0],

  // joined pair to the block
  output logic                 pair_val,
  input  logic                 pair_rdy,
  output logic [BIT_WIDTH-1:0] pair_input [ARRAY_LENGTH-1:0],
  output logic [BIT_WIDTH-1:0] pair_filter [ARRAY_LENGTH-1:0]
);

  logic                 input_full;
  logic                 filter_full;
  logic                 pair_take;
  logic [BIT_WIDTH-1:0] input_buf [ARRAY_LENGTH-1:0];
  logic [BIT_WIDTH-1:0] filter_buf [ARRAY_LENGTH-1:0];

  // ready only on empty buffers, never looks at val
  assign input_rdy  = !input_full;
  assign filter_rdy = !filter_full;

  // pair exists once both sides are held
  assign pair_val  = input_full && filter_full;
  assign pair_take = pair_val && pair_rdy;

  // full flags
  // a buffer cannot fill and drain in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      input_full  <= 1'b0;
      filter_full <= 1'b0;
    end else if (pair_take) begin
      input_full  <= 1'b0;
      filter_full <= 1'b0;
    end else begin
      if (input_val && input_rdy) input_full <= 1'b1;
      if (filter_val && filter_rdy) filter_full <= 1'b1;
    end
  end

  // buffer payloads, each on its own transfer
  always_ff @(posedge clk) begin
    if (input_val && input_rdy) input_buf <= input_msg;
    if (filter_val && filter_rdy) filter_buf <= filter_msg;
  end

  assign pair_input  = input_buf;
  assign pair_filter = filter_buf;

endmodule

`default_nettype wire

//--- source/fixed_point_multiplier.sv
// ==============================
// iterative signed fixed-point multiplier
// one multiplier bit per cycle, val/rdy in and out
// ==============================
`default_nettype none

module fixed_point_multiplier
  import conv_pkg::*;
#(
  parameter int BIT_WIDTH = DEFAULT_BIT_WIDTH,
  parameter int FRAC_BITS = DEFAULT_FRAC_BITS
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // request side
  input  logic                 recv_val,
  output logic                 recv_rdy,
  input  logic [BIT_WIDTH-1:0] a,
  input  logic [BIT_WIDTH-1:0] b,

  // response side
  output logic                 send_val,
  input  logic                 send_rdy,
  output logic [BIT_WIDTH-1:0] c
);

  localparam int CNT_W  = (BIT_WIDTH > 1) ? $clog2(BIT_WIDTH) : 1;
  localparam int PROD_W = 2 * BIT_WIDTH;

  mult_state_e state, state_next;

  logic                     accept;
  logic                     take;
  logic                     last_bit;
  logic [CNT_W-1:0]         bit_cnt;
  logic [BIT_WIDTH-1:0]     a_mag;
  logic [BIT_WIDTH-1:0]     b_mag;
  logic [PROD_W-1:0]        mcand;
  logic [BIT_WIDTH-1:0]     mplier;
  logic [PROD_W-1:0]        acc;
  logic [PROD_W-1:0]        acc_sum;
  logic                     neg;
  logic [PROD_W-1:0]        prod;
  logic signed [PROD_W-1:0] prod_shifted;

  // handshakes
  assign recv_rdy = (state == MULT_IDLE);
  assign send_val = (state == MULT_DONE);
  assign accept   = recv_val && recv_rdy;
  assign take     = send_val && send_rdy;

  // magnitudes, most negative word maps to 2**(BIT_WIDTH-1) unsigned
  assign a_mag = a[BIT_WIDTH-1] ? -a : a;
  assign b_mag = b[BIT_WIDTH-1] ? -b : b;

  // one partial product per cycle
  assign acc_sum  = mplier[0] ? (acc + mcand) : acc;
  assign last_bit = (bit_cnt == CNT_W'(BIT_WIDTH - 1));

  // ==============================
  // control
  // ==============================
  always_comb begin
    state_next = state;
    case (state)
      MULT_IDLE: if (accept) state_next = MULT_BUSY;
      MULT_BUSY: if (last_bit) state_next = MULT_DONE;
      MULT_DONE: if (take) state_next = MULT_IDLE;
      default:   state_next = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= MULT_IDLE;
      bit_cnt <= '0;
    end else begin
      state <= state_next;
      if (accept) begin
        bit_cnt <= '0;
      end else if (state == MULT_BUSY) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // ==============================
  // shift-add datapath
  // ==============================
  always_ff @(posedge clk) begin
    if (accept) begin
      mcand  <= {{BIT_WIDTH{1'b0}}, a_mag};
      mplier <= b_mag;
      acc    <= '0;
      neg    <= a[BIT_WIDTH-1] ^ b[BIT_WIDTH-1];
    end else if (state == MULT_BUSY) begin
      acc    <= acc_sum;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // restore sign, drop fraction bits, truncate to word
  assign prod         = neg ? -acc : acc;
  assign prod_shifted = $signed(prod) >>> FRAC_BITS;
  assign c            = prod_shifted[BIT_WIDTH-1:0];

endmodule

`default_nettype wire

//--- source/conv_pkg.sv
// ==============================
// convolution unit shared types
// fsm encodings and default sizes
// ==============================
`default_nettype none

package conv_pkg;

  // ==============================
  // default sizes
  // ==============================

  // word width in bits
  parameter int DEFAULT_BIT_WIDTH = 16;
  // elements per array
  parameter int DEFAULT_ARRAY_LENGTH = 4;
  // fraction bits, so 1.0 is 256 at the defaults
  parameter int DEFAULT_FRAC_BITS = 8;

  // ==============================
  // fsm encodings
  // ==============================

  // convolution block control
  typedef enum logic [1:0] {
    CONV_IDLE = 2'd0,
    CONV_CALC = 2'd1,
    CONV_DONE = 2'd2
  } conv_state_e;

  // iterative multiplier control
  typedef enum logic [1:0] {
    MULT_IDLE = 2'd0,
    MULT_BUSY = 2'd1,
    MULT_DONE = 2'd2
  } mult_state_e;

endpackage

`default_nettype wire
